// ==== common/mips_macros.svh ====
/*
 * MIPS32 core constants: widths, reset vector, halt address and $v0 index
 */
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define MIPS_WORD_W       32
`define MIPS_REG_ADDR_W   5
`define MIPS_RESET_VECTOR 32'hBFC0_0000
`define MIPS_HALT_ADDRESS 32'h0000_0000
`define MIPS_V0_INDEX     2

`endif

// ==== common/mips_isa_pkg.sv ====
/*
 * MIPS32 instruction-set types for the bus processor
 */
`include "mips_macros.svh"

package mips_isa_pkg;

	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [`MIPS_REG_ADDR_W-1:0] reg_addr_t;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDIU   = 6'b001001,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LW      = 6'b100011,
		OP_LBU     = 6'b100100,
		OP_SB      = 6'b101000,
		OP_SW      = 6'b101011
	} opcode_e;

	// function field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		FN_JR   = 6'b001000,
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_SLT  = 6'b101010
	} funct_e;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI} alu_op_e;

	typedef enum logic [2:0] {MEM_NONE, MEM_LW, MEM_LB, MEM_LBU, MEM_SW, MEM_SB} mem_op_e;

endpackage

// ==== common/mips_bus_pkg.sv ====
/*
 * Avalon-side types: sequencer states and byte-lane fields
 */
package mips_bus_pkg;

	// fetch, optional data access, one-cycle commit
	typedef enum logic [1:0] {
		SEQ_FETCH,
		SEQ_DATA,
		SEQ_COMMIT,
		SEQ_HALTED
	} seq_state_e;

	// one enable per byte lane, little-endian
	typedef logic [3:0] byte_en_t;

	// low two address bits
	typedef logic [1:0] byte_offset_t;

endpackage

// ==== core/mips_alu.sv ====
/*
 * Integer ALU for the supported arithmetic and logic instructions
 */
module mips_alu (
	input  mips_isa_pkg::alu_op_e alu_op,
	input  mips_isa_pkg::word_t   a,
	input  mips_isa_pkg::word_t   b,
	output mips_isa_pkg::word_t   result
);
	import mips_isa_pkg::*;

	always_comb begin
		case (alu_op)
			// ADDU and SUBU wrap, no overflow trap
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SLT: result = word_t'($signed(a) < $signed(b));
			ALU_LUI: result = b << 16;
			default: result = '0;
		endcase
	end

endmodule

// ==== core/mips_register_file.sv ====
/*
 * 32-entry register file, two read ports, one write port, $v0 tap
 */
`include "mips_macros.svh"

module mips_register_file (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    write_enable,
	input  mips_isa_pkg::reg_addr_t write_address,
	input  mips_isa_pkg::word_t     write_data,
	input  mips_isa_pkg::reg_addr_t read_address_1,
	input  mips_isa_pkg::reg_addr_t read_address_2,
	output mips_isa_pkg::word_t     read_data_1,
	output mips_isa_pkg::word_t     read_data_2,
	output mips_isa_pkg::word_t     v0
);
	import mips_isa_pkg::*;

	word_t regs [2**`MIPS_REG_ADDR_W];

	// $zero is never written, so it keeps its reset value
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**`MIPS_REG_ADDR_W; i++)
				regs[i] <= '0;
		end else if (write_enable && write_address != '0) begin
			regs[write_address] <= write_data;
		end
	end

	assign read_data_1 = regs[read_address_1];
	assign read_data_2 = regs[read_address_2];
	assign v0 = regs[`MIPS_V0_INDEX];

	zero_reg_reads_zero: assert property (@(posedge clk) disable iff (reset)
		read_address_1 == '0 |-> read_data_1 == '0);

endmodule

// ==== core/mips_decoder.sv ====
/*
 * Instruction decoder, turns the fetched word into datapath controls
 */
module mips_decoder (
	input  mips_isa_pkg::word_t     instruction,
	output mips_isa_pkg::alu_op_e   alu_op,
	output logic                    use_imm,
	output logic                    zero_extend,
	output logic                    reg_dst_rd,
	output logic                    mem_to_reg,
	output logic                    reg_write,
	output logic                    branch_eq,
	output logic                    branch_ne,
	output logic                    jump,
	output logic                    jump_reg,
	output mips_isa_pkg::mem_op_e   mem_op,
	output mips_isa_pkg::reg_addr_t rs,
	output mips_isa_pkg::reg_addr_t rt,
	output mips_isa_pkg::reg_addr_t rd
);
	import mips_isa_pkg::*;

	opcode_e opcode;
	funct_e  funct;

	assign opcode = opcode_e'(instruction[31:26]);
	assign funct = funct_e'(instruction[5:0]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];

	always_comb begin
		// anything not matched below stays a no-op
		alu_op = ALU_ADD;
		use_imm = 1'b0;
		zero_extend = 1'b0;
		reg_dst_rd = 1'b0;
		mem_to_reg = 1'b0;
		reg_write = 1'b0;
		branch_eq = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		mem_op = MEM_NONE;
		case (opcode)
			OP_SPECIAL: begin
				reg_dst_rd = 1'b1;
				reg_write = 1'b1;
				case (funct)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_JR: begin
						reg_write = 1'b0;
						jump_reg = 1'b1;
					end
					default: reg_write = 1'b0;
				endcase
			end
			OP_J:   jump = 1'b1;
			OP_BEQ: branch_eq = 1'b1;
			OP_BNE: branch_ne = 1'b1;
			OP_ADDIU: begin
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_ANDI, OP_ORI: begin
				alu_op = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
				use_imm = 1'b1;
				zero_extend = 1'b1;
				reg_write = 1'b1;
			end
			OP_LUI: begin
				alu_op = ALU_LUI;
				use_imm = 1'b1;
				reg_write = 1'b1;
			end
			OP_LW, OP_LB, OP_LBU: begin
				use_imm = 1'b1;
				mem_to_reg = 1'b1;
				reg_write = 1'b1;
				mem_op = (opcode == OP_LW) ? MEM_LW : (opcode == OP_LB) ? MEM_LB : MEM_LBU;
			end
			OP_SW, OP_SB: begin
				use_imm = 1'b1;
				mem_op = (opcode == OP_SW) ? MEM_SW : MEM_SB;
			end
			default: ;
		endcase
	end

endmodule

// ==== core/mips_datapath.sv ====
/*
 * Datapath: program counter, operand and writeback select, branch compare
 */
`include "mips_macros.svh"

module mips_datapath (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    commit,
	input  mips_isa_pkg::alu_op_e   alu_op,
	input  logic                    use_imm,
	input  logic                    zero_extend,
	input  logic                    reg_dst_rd,
	input  logic                    mem_to_reg,
	input  logic                    reg_write,
	input  logic                    branch_eq,
	input  logic                    branch_ne,
	input  logic                    jump,
	input  logic                    jump_reg,
	input  mips_isa_pkg::reg_addr_t rs,
	input  mips_isa_pkg::reg_addr_t rt,
	input  mips_isa_pkg::reg_addr_t rd,
	input  mips_isa_pkg::word_t     load_value,
	input  logic [25:0]             imm_field,
	output mips_isa_pkg::word_t     pc,
	output mips_isa_pkg::word_t     data_address,
	output mips_isa_pkg::word_t     store_data,
	output logic                    halt_request,
	output mips_isa_pkg::word_t     register_v0
);
	import mips_isa_pkg::*;

	word_t     rs_value;
	word_t     rt_value;
	word_t     sign_imm;
	word_t     alu_b;
	word_t     alu_result;
	word_t     pc_plus4;
	word_t     branch_target;
	word_t     jump_target;
	word_t     next_pc;
	reg_addr_t write_address;
	word_t     write_data;
	logic      branch_taken;

	assign sign_imm = {{16{imm_field[15]}}, imm_field[15:0]};
	assign alu_b = !use_imm ? rt_value : zero_extend ? {16'h0000, imm_field[15:0]} : sign_imm;

	assign write_address = reg_dst_rd ? rd : rt;
	assign write_data = mem_to_reg ? load_value : alu_result;

	mips_register_file register_file_i (
		.clk(clk), .reset(reset), .write_enable(commit && reg_write),
		.write_address(write_address), .write_data(write_data),
		.read_address_1(rs), .read_address_2(rt),
		.read_data_1(rs_value), .read_data_2(rt_value), .v0(register_v0)
	);

	mips_alu alu_i (.alu_op(alu_op), .a(rs_value), .b(alu_b), .result(alu_result));

	assign data_address = alu_result;
	assign store_data = rt_value;

	// no delay slot, taken branches go straight to the target
	assign pc_plus4 = pc + word_t'(4);
	assign branch_target = pc_plus4 + (sign_imm << 2);
	assign jump_target = {pc_plus4[31:28], imm_field, 2'b00};
	assign branch_taken = (branch_eq && rs_value == rt_value) ||
		(branch_ne && rs_value != rt_value);

	always_comb begin
		if (jump_reg)
			next_pc = rs_value;
		else if (jump)
			next_pc = jump_target;
		else if (branch_taken)
			next_pc = branch_target;
		else
			next_pc = pc_plus4;
	end

	assign halt_request = jump_reg && rs_value == `MIPS_HALT_ADDRESS;

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			pc <= `MIPS_RESET_VECTOR;
		else if (commit)
			pc <= next_pc;
	end

endmodule

// ==== bus/mips_byte_lanes.sv ====
/*
 * Byte-lane handling: enables, store placement and load extraction
 */
module mips_byte_lanes (
	input  mips_isa_pkg::mem_op_e      mem_op,
	input  mips_bus_pkg::byte_offset_t offset,
	input  mips_isa_pkg::word_t        store_data,
	input  mips_isa_pkg::word_t        load_data,
	output mips_bus_pkg::byte_en_t     lane_byteenable,
	output mips_isa_pkg::word_t        lane_writedata,
	output mips_isa_pkg::word_t        load_value
);
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;

	logic       byte_access;
	logic [4:0] lane_shift;
	word_t      lane_word;
	logic [7:0] lane_byte;

	assign byte_access = mem_op inside {MEM_LB, MEM_LBU, MEM_SB};

	// lane k holds bits 8k+7..8k
	assign lane_shift = {offset, 3'b000};

	// one-hot for byte accesses
	assign lane_byteenable = byte_access ? byte_en_t'(4'b0001 << offset) : 4'b1111;

	// SB moves the low byte up to its lane
	assign lane_writedata = (mem_op == MEM_SB) ?
		word_t'(store_data[7:0]) << lane_shift : store_data;

	assign lane_word = load_data >> lane_shift;
	assign lane_byte = lane_word[7:0];

	always_comb begin
		case (mem_op)
			MEM_LB:  load_value = {{24{lane_byte[7]}}, lane_byte};
			MEM_LBU: load_value = {24'h000000, lane_byte};
			default: load_value = load_data;
		endcase
	end

endmodule

// ==== bus/mips_bus_sequencer.sv ====
/*
 * Avalon-MM sequencer, steps fetch, optional data access and commit
 */
module mips_bus_sequencer (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   waitrequest,
	input  mips_isa_pkg::word_t    readdata,
	input  mips_isa_pkg::mem_op_e  mem_op,
	input  mips_isa_pkg::word_t    pc,
	input  mips_isa_pkg::word_t    data_address,
	input  logic                   halt_request,
	input  mips_bus_pkg::byte_en_t lane_byteenable,
	input  mips_isa_pkg::word_t    lane_writedata,
	output mips_isa_pkg::word_t    address,
	output logic                   read,
	output logic                   write,
	output mips_bus_pkg::byte_en_t byteenable,
	output mips_isa_pkg::word_t    writedata,
	output mips_isa_pkg::word_t    instruction,
	output mips_isa_pkg::word_t    load_data,
	output logic                   commit,
	output logic                   active
);
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	word_t      instruction_q;
	word_t      load_data_q;
	logic       is_store;

	// decode straight off the bus while fetching, so the fetch edge
	// can already pick between the data phase and commit
	assign instruction = (state == SEQ_FETCH) ? readdata : instruction_q;
	assign load_data = load_data_q;

	assign is_store = mem_op inside {MEM_SW, MEM_SB};

	always_comb begin
		state_next = state;
		case (state)
			SEQ_FETCH:
				if (!waitrequest)
					state_next = (mem_op != MEM_NONE) ? SEQ_DATA : SEQ_COMMIT;
			SEQ_DATA:
				if (!waitrequest)
					state_next = SEQ_COMMIT;
			SEQ_COMMIT:
				state_next = halt_request ? SEQ_HALTED : SEQ_FETCH;
			default:
				state_next = SEQ_HALTED;
		endcase
	end

	always_ff @(posedge clk, posedge reset) begin
		if (reset)
			state <= SEQ_FETCH;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (state == SEQ_FETCH && !waitrequest)
			instruction_q <= readdata;
		if (state == SEQ_DATA && !waitrequest)
			load_data_q <= readdata;
	end

	// port mux, word-aligned address
	assign read = (state == SEQ_FETCH) || (state == SEQ_DATA && !is_store);
	assign write = (state == SEQ_DATA) && is_store;
	assign address = (state == SEQ_DATA) ? {data_address[31:2], 2'b00} : {pc[31:2], 2'b00};
	assign byteenable = (state == SEQ_DATA) ? lane_byteenable : 4'b1111;
	assign writedata = (state == SEQ_DATA) ? lane_writedata : '0;

	assign commit = (state == SEQ_COMMIT);
	assign active = (state != SEQ_HALTED);

	read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(read && write));

	request_held_in_wait: assert property (@(posedge clk) disable iff (reset)
		(read || write) && waitrequest |=>
			$stable({read, write, address, byteenable, writedata}));

endmodule

// ==== design/mips_cpu_bus.sv ====
/*
 * MIPS32 processor top level with one Avalon-MM master port
 */
module mips_cpu_bus (
	input  logic                  clk,
	input  logic                  reset,
	output logic                  active,
	output mips_isa_pkg::word_t   register_v0,
	output mips_isa_pkg::word_t   address,
	output logic                  read,
	output logic                  write,
	input  logic                  waitrequest,
	output mips_isa_pkg::word_t   writedata,
	output mips_bus_pkg::byte_en_t byteenable,
	input  mips_isa_pkg::word_t   readdata
);
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;

	word_t     instruction;
	word_t     load_data;
	word_t     load_value;
	word_t     pc;
	word_t     data_address;
	word_t     store_data;
	word_t     lane_writedata;
	byte_en_t  lane_byteenable;
	logic      commit;
	logic      halt_request;

	// decoder controls
	alu_op_e   alu_op;
	mem_op_e   mem_op;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic      use_imm;
	logic      zero_extend;
	logic      reg_dst_rd;
	logic      mem_to_reg;
	logic      reg_write;
	logic      branch_eq;
	logic      branch_ne;
	logic      jump;
	logic      jump_reg;

	mips_bus_sequencer sequencer_i (
		.clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
		.mem_op(mem_op), .pc(pc), .data_address(data_address), .halt_request(halt_request),
		.lane_byteenable(lane_byteenable), .lane_writedata(lane_writedata),
		.address(address), .read(read), .write(write), .byteenable(byteenable),
		.writedata(writedata), .instruction(instruction), .load_data(load_data),
		.commit(commit), .active(active)
	);

	mips_byte_lanes byte_lanes_i (
		.mem_op(mem_op), .offset(data_address[1:0]), .store_data(store_data),
		.load_data(load_data), .lane_byteenable(lane_byteenable),
		.lane_writedata(lane_writedata), .load_value(load_value)
	);

	mips_decoder decoder_i (
		.instruction(instruction), .alu_op(alu_op), .use_imm(use_imm),
		.zero_extend(zero_extend), .reg_dst_rd(reg_dst_rd), .mem_to_reg(mem_to_reg),
		.reg_write(reg_write), .branch_eq(branch_eq), .branch_ne(branch_ne),
		.jump(jump), .jump_reg(jump_reg), .mem_op(mem_op), .rs(rs), .rt(rt), .rd(rd)
	);

	mips_datapath datapath_i (
		.clk(clk), .reset(reset), .commit(commit), .alu_op(alu_op), .use_imm(use_imm),
		.zero_extend(zero_extend), .reg_dst_rd(reg_dst_rd), .mem_to_reg(mem_to_reg),
		.reg_write(reg_write), .branch_eq(branch_eq), .branch_ne(branch_ne),
		.jump(jump), .jump_reg(jump_reg), .rs(rs), .rt(rt), .rd(rd),
		.load_value(load_value), .imm_field(instruction[25:0]), .pc(pc),
		.data_address(data_address), .store_data(store_data),
		.halt_request(halt_request), .register_v0(register_v0)
	);

endmodule

// ==== sim/avalon_memory_model.sv ====
/*
 * Avalon-MM slave memory for the testbench, program words at the reset
 * vector and one data word, with pseudo-random waitrequest
 */
`include "mips_macros.svh"

module avalon_memory_model #(
	parameter int PROG_LEN = 12,
	parameter logic [31:0] DATA_ADDRESS = 32'h0000_0100
) (
	input  logic                   clk,
	input  mips_isa_pkg::word_t    address,
	input  logic                   read,
	input  logic                   write,
	input  mips_bus_pkg::byte_en_t byteenable,
	input  mips_isa_pkg::word_t    writedata,
	output mips_isa_pkg::word_t    readdata,
	output logic                   waitrequest,
	output int                     bus_errors
);
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;

	word_t       prog [PROG_LEN];
	word_t       data_word;
	word_t       prog_offset;
	logic [31:0] rnd;
	opcode_e     fetched_op;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial begin
		rnd = 32'h2928_d914;
		waitrequest = 1'b1;
		bus_errors = 0;
	end

	// stall about one cycle in four
	always begin
		@(posedge clk);
		#1;
		rnd = xorshift(rnd);
		waitrequest = rnd[3] & rnd[9];
	end

	assign prog_offset = address - `MIPS_RESET_VECTOR;

	always_comb begin
		readdata = '0;
		if (address == DATA_ADDRESS)
			readdata = data_word;
		else if (prog_offset < PROG_LEN * 4)
			readdata = prog[int'(prog_offset >> 2)];
	end

	always @(posedge clk) begin
		if (!waitrequest && (read || write)) begin
			if (address == DATA_ADDRESS) begin
				// byte accesses enable one lane, word accesses all four
				assert (fetched_op inside {OP_LB, OP_LBU, OP_SB} ?
						$onehot(byteenable) : byteenable == 4'b1111) else begin
					bus_errors++;
					$display("bad byteenable %b on data access at time %0t", byteenable, $time);
				end
				if (write) begin
					for (int k = 0; k < 4; k++)
						if (byteenable[k])
							data_word[8*k +: 8] <= writedata[8*k +: 8];
				end
			end else begin
				assert (!write && prog_offset < PROG_LEN * 4) else begin
					bus_errors++;
					$display("unexpected access to address %h at time %0t", address, $time);
				end
				// opcode of the last fetch sets the width of the next data access
				fetched_op <= opcode_e'(readdata[31:26]);
			end
		end
	end

endmodule

// ==== sim/mips_cpu_bus_tb.sv ====
/*
 * Testbench for the MIPS32 bus processor, runs a table of small programs
 */
`include "mips_macros.svh"

module mips_cpu_bus_tb;
	import mips_isa_pkg::*;
	import mips_bus_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 9;
	localparam int PROG_LEN = 12;
	localparam word_t DATA_ADDRESS = 32'h0000_0100;
	localparam longint TIMEOUT = (NUM_TESTS * PROG_LEN * 3 * 8 + NUM_TESTS * 12) * CLK_PERIOD;

	logic     clk;
	logic     reset;
	logic     active;
	word_t    register_v0;
	word_t    address;
	logic     read;
	logic     write;
	logic     waitrequest;
	word_t    writedata;
	byte_en_t byteenable;
	word_t    readdata;
	int       bus_errors;
	int       check_errors;

	word_t prog_table [NUM_TESTS][PROG_LEN];
	word_t data_table [NUM_TESTS];
	word_t v0_table [NUM_TESTS];
	word_t mem_table [NUM_TESTS];
	int    fill_count [NUM_TESTS];

	mips_cpu_bus dut_i (
		.clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
		.address(address), .read(read), .write(write), .waitrequest(waitrequest),
		.writedata(writedata), .byteenable(byteenable), .readdata(readdata)
	);

	avalon_memory_model #(.PROG_LEN(PROG_LEN), .DATA_ADDRESS(DATA_ADDRESS)) mem_i (
		.clk(clk), .address(address), .read(read), .write(write), .byteenable(byteenable),
		.writedata(writedata), .readdata(readdata), .waitrequest(waitrequest),
		.bus_errors(bus_errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t enc_r(funct_e fn, int rs, int rt, int rd);
		return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
	endfunction

	function automatic word_t enc_i(opcode_e op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	// target given as a word index into the program
	function automatic word_t enc_j(int index);
		word_t target;
		target = `MIPS_RESET_VECTOR + word_t'(4 * index);
		return {OP_J, target[27:2]};
	endfunction

	function automatic word_t sext8(logic [7:0] b);
		return {{24{b[7]}}, b};
	endfunction

	task automatic emit(input int t, input word_t w);
		prog_table[t][fill_count[t]] = w;
		fill_count[t]++;
	endtask

	task automatic build_table();
		word_t a;
		word_t b;
		word_t c;
		word_t x;
		for (int t = 0; t < NUM_TESTS; t++) begin
			fill_count[t] = 0;
			for (int i = 0; i < PROG_LEN; i++)
				prog_table[t][i] = enc_r(FN_JR, 0, 0, 0);
		end
		// ALU chain
		emit(0, enc_i(OP_ADDIU, 0, 8, 16'd7));
		emit(0, enc_i(OP_ADDIU, 0, 9, 16'hFFFD));
		emit(0, enc_r(FN_ADDU, 8, 9, 10));
		emit(0, enc_r(FN_SUBU, 10, 9, 11));
		emit(0, enc_r(FN_SLT, 9, 8, 12));
		emit(0, enc_r(FN_XOR, 11, 12, 13));
		emit(0, enc_i(OP_LUI, 0, 14, 16'h1234));
		emit(0, enc_i(OP_ORI, 14, 14, 16'h5678));
		emit(0, enc_r(FN_OR, 14, 13, 2));
		emit(0, enc_i(OP_ANDI, 2, 2, 16'hFF0F));
		emit(0, enc_r(FN_AND, 2, 14, 2));
		a = 32'd7;
		b = 32'hFFFF_FFFD;
		c = {16'h1234, 16'h0000} | 32'h0000_5678;
		x = ((a + b) - b) ^ word_t'($signed(b) < $signed(a));
		data_table[0] = 32'h1122_3344;
		v0_table[0] = ((c | x) & 32'h0000_FF0F) & c;
		mem_table[0] = data_table[0];
		// LW
		emit(1, enc_i(OP_LW, 0, 2, 16'h0100));
		data_table[1] = 32'h8091_A2B3;
		v0_table[1] = data_table[1];
		mem_table[1] = data_table[1];
		// LB at offsets 0..2, LBU at 3, then LBU at 0..2, LB at 3
		for (int t = 2; t <= 3; t++) begin
			emit(t, enc_i(t == 2 ? OP_LB : OP_LBU, 0, 8, 16'h0100));
			emit(t, enc_i(t == 2 ? OP_LB : OP_LBU, 0, 9, 16'h0101));
			emit(t, enc_i(t == 2 ? OP_LB : OP_LBU, 0, 10, 16'h0102));
			emit(t, enc_i(t == 2 ? OP_LBU : OP_LB, 0, 11, 16'h0103));
			emit(t, enc_r(FN_ADDU, 8, 9, 2));
			emit(t, enc_r(FN_ADDU, 2, 10, 2));
			emit(t, enc_r(FN_ADDU, 2, 11, 2));
			data_table[t] = 32'h8091_A2B3;
			mem_table[t] = data_table[t];
		end
		v0_table[2] = sext8(8'hB3) + sext8(8'hA2) + sext8(8'h91) + 32'h80;
		v0_table[3] = 32'hB3 + 32'hA2 + 32'h91 + sext8(8'h80);
		// SB at offsets 0 and 2, then 1 and 3
		emit(4, enc_i(OP_ADDIU, 0, 8, 16'h0055));
		emit(4, enc_i(OP_SB, 0, 8, 16'h0100));
		emit(4, enc_i(OP_ADDIU, 0, 8, 16'h0066));
		emit(4, enc_i(OP_SB, 0, 8, 16'h0102));
		emit(4, enc_i(OP_LW, 0, 2, 16'h0100));
		data_table[4] = 32'hAABB_CCDD;
		v0_table[4] = {8'hAA, 8'h66, 8'hCC, 8'h55};
		mem_table[4] = v0_table[4];
		emit(5, enc_i(OP_ADDIU, 0, 8, 16'h01EE));
		emit(5, enc_i(OP_SB, 0, 8, 16'h0101));
		emit(5, enc_i(OP_SB, 0, 8, 16'h0103));
		emit(5, enc_i(OP_LW, 0, 2, 16'h0100));
		data_table[5] = 32'hAABB_CCDD;
		v0_table[5] = {8'hEE, 8'hBB, 8'hEE, 8'hDD};
		mem_table[5] = v0_table[5];
		// SW
		emit(6, enc_i(OP_LUI, 0, 8, 16'hDEAD));
		emit(6, enc_i(OP_ORI, 8, 8, 16'hBEEF));
		emit(6, enc_i(OP_SW, 0, 8, 16'h0100));
		emit(6, enc_i(OP_LW, 0, 2, 16'h0100));
		data_table[6] = 32'h0123_4567;
		v0_table[6] = 32'hDEAD_BEEF;
		mem_table[6] = 32'hDEAD_BEEF;
		// branches, each marker tells which path ran
		emit(7, enc_i(OP_ADDIU, 0, 8, 16'd5));
		emit(7, enc_i(OP_ADDIU, 0, 9, 16'd5));
		emit(7, enc_i(OP_BEQ, 8, 9, 16'd1));
		emit(7, enc_i(OP_ADDIU, 2, 2, 16'h0001));
		emit(7, enc_i(OP_BNE, 8, 9, 16'd1));
		emit(7, enc_i(OP_ADDIU, 2, 2, 16'h0010));
		emit(7, enc_i(OP_BEQ, 8, 0, 16'd1));
		emit(7, enc_i(OP_ADDIU, 2, 2, 16'h0100));
		emit(7, enc_i(OP_BNE, 8, 0, 16'd1));
		emit(7, enc_i(OP_ADDIU, 2, 2, 16'h1000));
		data_table[7] = 32'h0;
		v0_table[7] = 32'h0000_0110;
		mem_table[7] = 32'h0;
		// J over one marker
		emit(8, enc_i(OP_ADDIU, 0, 2, 16'h0001));
		emit(8, enc_j(3));
		emit(8, enc_i(OP_ADDIU, 2, 2, 16'h0040));
		emit(8, enc_i(OP_ADDIU, 2, 2, 16'h0020));
		data_table[8] = 32'h0;
		v0_table[8] = 32'h0000_0021;
		mem_table[8] = 32'h0;
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		assert (got === expected) else begin
			check_errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected);
		end
	endtask

	task automatic run_test(input int t);
		@(posedge clk);
		#1 reset = 1'b1;
		for (int i = 0; i < PROG_LEN; i++)
			mem_i.prog[i] = prog_table[t][i];
		mem_i.data_word = data_table[t];
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		// first request after reset
		check_value("read", word_t'(read), 32'd1);
		check_value("write", word_t'(write), 32'd0);
		check_value("address", address, `MIPS_RESET_VECTOR);
		check_value("byteenable", word_t'(byteenable), 32'h0000_000F);
		check_value("active", word_t'(active), 32'd1);
		while (active === 1'b1)
			@(negedge clk);
		repeat (3) begin
			@(negedge clk);
			check_value("read", word_t'(read), 32'd0);
			check_value("write", word_t'(write), 32'd0);
		end
		check_value("register_v0", register_v0, v0_table[t]);
		check_value("data_word", mem_i.data_word, mem_table[t]);
	endtask

	initial begin
		#(TIMEOUT);
		$display("timeout: the processor did not halt within %0d time units", TIMEOUT);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		check_errors = 0;
		build_table();
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("errors: %0d check, %0d bus", check_errors, bus_errors);
		if (check_errors == 0 && bus_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+common
common/mips_isa_pkg.sv
common/mips_bus_pkg.sv
core/mips_alu.sv
core/mips_register_file.sv
core/mips_decoder.sv
core/mips_datapath.sv
bus/mips_byte_lanes.sv
bus/mips_bus_sequencer.sv
design/mips_cpu_bus.sv
sim/avalon_memory_model.sv
sim/mips_cpu_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the MIPS32 bus processor testbench

VERILATOR ?= verilator
TOP       ?= mips_cpu_bus_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
